// ==== all.f ====
hdl/toll_pkg.sv
hdl/tag_checker.sv
hdl/lane_selector.sv
hdl/toll_gate.sv
hdl/toll_plaza.sv
testbench/toll_plaza_properties.sv
testbench/toll_plaza_tb.sv

// ==== hdl/lane_selector.sv ====
`timescale 1ns/1ps

module lane_selector import toll_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                vehicle_valid,
    input  vehicle_type_e       vehicle_type,
    input  lane_counts_t        lane_counts,
    output logic [lane_w-1:0]   lane_pick
);

    logic [lane_w-1:0]  first_lane;
    logic [count_w-1:0] count_first;
    logic [count_w-1:0] count_second;
    logic [lane_w-1:0]  next_pick;

    // Each type owns two neighbouring lanes
    always_comb begin
        first_lane   = lane_none;
        count_first  = '0;
        count_second = '0;
        case (vehicle_type)
            type_truck: begin
                first_lane   = lane_truck;
                count_first  = lane_counts[0];
                count_second = lane_counts[1];
            end
            type_car: begin
                first_lane   = lane_car;
                count_first  = lane_counts[2];
                count_second = lane_counts[3];
            end
            type_bike: begin
                first_lane   = lane_bike;
                count_first  = lane_counts[4];
                count_second = lane_counts[5];
            end
            default: begin
                first_lane = lane_none;
            end
        endcase
    end

    // Tie goes to the lower-numbered lane
    always_comb begin
        if (first_lane == lane_none) begin
            next_pick = lane_none;
        end else if (count_second < count_first) begin
            next_pick = first_lane + lane_w'(1);
        end else begin
            next_pick = first_lane;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_pick <= lane_none;
        end else if (vehicle_valid) begin
            lane_pick <= next_pick;
        end
    end

endmodule

// ==== hdl/tag_checker.sv ====
`timescale 1ns/1ps

module tag_checker import toll_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               vehicle_valid,
    input  logic [digit_w-1:0] tag_a,
    input  logic [digit_w-1:0] tag_b,
    input  logic [digit_w-1:0] tag_c,
    input  logic [digit_w-1:0] tag_d,
    output logic               tag_done,
    output logic               tag_ok
);

    // Luhn doubling, a double above 9 loses 9
    function automatic logic [digit_w-1:0] luhn_double(input logic [digit_w-1:0] digit);
        logic [digit_w:0] twice;
        twice = {digit, 1'b0};
        if (twice > 5'd9) begin
            twice = twice - 5'd9;
        end
        return twice[digit_w-1:0];
    endfunction

    logic       digits_bcd;
    logic [5:0] digit_sum;
    logic       sum_ok;

    assign digits_bcd = (tag_a <= 4'd9) && (tag_b <= 4'd9) &&
                        (tag_c <= 4'd9) && (tag_d <= 4'd9);

    // Digits 0 and 2 are doubled, 1 and 3 count as read
    assign digit_sum = 6'(luhn_double(tag_a)) + 6'(tag_b) +
                       6'(luhn_double(tag_c)) + 6'(tag_d);

    // Sum never exceeds 36 for BCD digits
    assign sum_ok = (digit_sum == 6'd0)  || (digit_sum == 6'd10) ||
                    (digit_sum == 6'd20) || (digit_sum == 6'd30);

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_done <= 1'b0;
        end else begin
            tag_done <= vehicle_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (vehicle_valid) begin
            tag_ok <= digits_bcd && sum_ok;
        end
    end

endmodule

// ==== hdl/toll_gate.sv ====
`timescale 1ns/1ps

module toll_gate import toll_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tag_done,
    input  logic                 tag_ok,
    input  logic [lane_w-1:0]    lane_pick,
    input  vehicle_type_e        vehicle_type,
    input  logic [balance_w-1:0] balance,
    input  logic [lane_num-1:0]  lane_leave,
    output logic                 decision_valid,
    output decision_e            decision,
    output logic [lane_w-1:0]    lane,
    output lane_counts_t         lane_counts
);

    logic [balance_w-1:0] toll;
    logic                 toll_known;
    decision_e            next_decision;
    logic                 admit;
    logic [lane_num-1:0]  admit_lane;

    always_comb begin
        toll       = toll_truck;
        toll_known = 1'b1;
        case (vehicle_type)
            type_truck: toll = toll_truck;
            type_car:   toll = toll_car;
            type_bike:  toll = toll_bike;
            default:    toll_known = 1'b0;
        endcase
    end

    // Bad tags pay cash whatever the balance
    always_comb begin
        if (!tag_ok) begin
            next_decision = dec_cash;
        end else if (toll_known && (balance >= toll) && (lane_pick != lane_none)) begin
            next_decision = dec_admit;
        end else begin
            next_decision = dec_decline;
        end
    end

    assign admit = tag_done && (next_decision == dec_admit);

    always_comb begin
        for (int i = 0; i < lane_num; i++) begin
            admit_lane[i] = admit && (lane_pick == lane_w'(i + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decision_valid <= 1'b0;
            decision       <= dec_cash;
            lane           <= lane_none;
        end else begin
            decision_valid <= tag_done;
            if (tag_done) begin
                decision <= next_decision;
                lane     <= (next_decision == dec_admit) ? lane_pick : lane_none;
            end
        end
    end

    // Admit and leave on the same lane cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            lane_counts <= '0;
        end else begin
            for (int i = 0; i < lane_num; i++) begin
                if (admit_lane[i] && !lane_leave[i] && (lane_counts[i] != count_max)) begin
                    lane_counts[i] <= lane_counts[i] + count_w'(1);
                end else if (lane_leave[i] && !admit_lane[i] && (lane_counts[i] != '0)) begin
                    lane_counts[i] <= lane_counts[i] - count_w'(1);
                end
            end
        end
    end

endmodule

// ==== hdl/toll_pkg.sv ====
package toll_pkg;

    // Tag digits and account balance
    localparam int digit_w   = 4;
    localparam int balance_w = 4;

    // Lane queues
    localparam int lane_num = 6;
    localparam int count_w  = 3;
    localparam logic [count_w-1:0] count_max = count_w'(7);

    // Lanes are numbered 1 to 6, zero means no lane assigned
    localparam int lane_w = 3;
    localparam logic [lane_w-1:0] lane_none  = lane_w'(0);
    localparam logic [lane_w-1:0] lane_truck = lane_w'(1);
    localparam logic [lane_w-1:0] lane_car   = lane_w'(3);
    localparam logic [lane_w-1:0] lane_bike  = lane_w'(5);

    localparam logic [balance_w-1:0] toll_truck = balance_w'(5);
    localparam logic [balance_w-1:0] toll_car   = balance_w'(4);
    localparam logic [balance_w-1:0] toll_bike  = balance_w'(2);

    // Code 3 is not a vehicle
    typedef enum logic [1:0] {
        type_truck = 2'd0,
        type_car   = 2'd1,
        type_bike  = 2'd2
    } vehicle_type_e;

    typedef enum logic [1:0] {
        dec_admit   = 2'd0,
        dec_decline = 2'd1,
        dec_cash    = 2'd2
    } decision_e;

    // Element 0 holds the queue of lane 1
    typedef logic [lane_num-1:0][count_w-1:0] lane_counts_t;

endpackage

// ==== hdl/toll_plaza.sv ====
`timescale 1ns/1ps

module toll_plaza import toll_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 vehicle_valid,
    input  logic [digit_w-1:0]   tag_a,
    input  logic [digit_w-1:0]   tag_b,
    input  logic [digit_w-1:0]   tag_c,
    input  logic [digit_w-1:0]   tag_d,
    input  vehicle_type_e        vehicle_type,
    input  logic [balance_w-1:0] balance,
    input  logic [lane_num-1:0]  lane_leave,
    output logic                 decision_valid,
    output decision_e            decision,
    output logic [lane_w-1:0]    lane,
    output lane_counts_t         lane_counts
);

    logic                 tag_done;
    logic                 tag_ok;
    logic [lane_w-1:0]    lane_pick;
    vehicle_type_e        vehicle_type_q;
    logic [balance_w-1:0] balance_q;

    // Line up type and balance with the tag and lane results
    always_ff @(posedge clk) begin
        vehicle_type_q <= vehicle_type;
        balance_q      <= balance;
    end

    tag_checker u_tag (
        .clk           (clk),
        .reset         (reset),
        .vehicle_valid (vehicle_valid),
        .tag_a         (tag_a),
        .tag_b         (tag_b),
        .tag_c         (tag_c),
        .tag_d         (tag_d),
        .tag_done      (tag_done),
        .tag_ok        (tag_ok)
    );

    lane_selector u_lane (
        .clk           (clk),
        .reset         (reset),
        .vehicle_valid (vehicle_valid),
        .vehicle_type  (vehicle_type),
        .lane_counts   (lane_counts),
        .lane_pick     (lane_pick)
    );

    toll_gate u_gate (
        .clk            (clk),
        .reset          (reset),
        .tag_done       (tag_done),
        .tag_ok         (tag_ok),
        .lane_pick      (lane_pick),
        .vehicle_type   (vehicle_type_q),
        .balance        (balance_q),
        .lane_leave     (lane_leave),
        .decision_valid (decision_valid),
        .decision       (decision),
        .lane           (lane),
        .lane_counts    (lane_counts)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module toll_plaza_tb -f all.f
./obj_dir/Vtoll_plaza_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// ==== testbench/toll_plaza_properties.sv ====
`timescale 1ns/1ps

module toll_plaza_properties import toll_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              vehicle_valid,
    input vehicle_type_e     vehicle_type,
    input logic              decision_valid,
    input decision_e         decision,
    input logic [lane_w-1:0] lane
);

    // Two register stages between arrival and decision
    latency_two: assert property (@(posedge clk) disable iff (reset)
        decision_valid == $past(vehicle_valid, 2))
        else $error("decision_valid is not two cycles after vehicle_valid");

    lane_only_on_admit: assert property (@(posedge clk) disable iff (reset)
        (decision != dec_admit) |-> (lane == lane_none))
        else $error("lane assigned to a vehicle that was not admitted");

    legal_type: assert property (@(posedge clk) disable iff (reset)
        vehicle_valid |-> (2'(vehicle_type) != 2'd3))
        else $error("illegal vehicle type code on an arrival");

    quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !decision_valid)
        else $error("decision_valid high during reset");

endmodule

bind toll_plaza toll_plaza_properties u_props (
    .clk            (clk),
    .reset          (reset),
    .vehicle_valid  (vehicle_valid),
    .vehicle_type   (vehicle_type),
    .decision_valid (decision_valid),
    .decision       (decision),
    .lane           (lane)
);

// ==== testbench/toll_plaza_tb.sv ====
`timescale 1ns/1ps

module toll_plaza_tb import toll_pkg::*; ();

    localparam int table_size   = 17;
    localparam int random_count = 40;
    localparam int wait_limit   = 10;

    typedef struct packed {
        logic [digit_w-1:0]   a;
        logic [digit_w-1:0]   b;
        logic [digit_w-1:0]   c;
        logic [digit_w-1:0]   d;
        vehicle_type_e        vtype;
        logic [balance_w-1:0] bal;
        logic [lane_num-1:0]  leave;
        decision_e            dec;
        logic [lane_w-1:0]    lane;
        lane_counts_t         counts;
    } stim_row_t;

    // Leave bits pulse on the decision edge
    // Counts in octal with lane 1 as the rightmost digit
    stim_row_t rows [table_size] = '{
        '{4'd1, 4'd2,  4'd3, 4'd4, type_truck, 4'd15, 6'b000000, dec_cash,    3'd0, 18'o000000},
        '{4'd0, 4'd10, 4'd0, 4'd0, type_car,   4'd15, 6'b000000, dec_cash,    3'd0, 18'o000000},
        '{4'd1, 4'd2,  4'd3, 4'd0, type_truck, 4'd15, 6'b000000, dec_admit,   3'd1, 18'o000001},
        '{4'd7, 4'd3,  4'd8, 4'd5, type_truck, 4'd15, 6'b000000, dec_admit,   3'd2, 18'o000011},
        '{4'd9, 4'd9,  4'd9, 4'd3, type_truck, 4'd5,  6'b000000, dec_admit,   3'd1, 18'o000012},
        '{4'd1, 4'd2,  4'd3, 4'd0, type_car,   4'd4,  6'b000000, dec_admit,   3'd3, 18'o000112},
        '{4'd7, 4'd3,  4'd8, 4'd5, type_car,   4'd15, 6'b000000, dec_admit,   3'd4, 18'o001112},
        '{4'd9, 4'd9,  4'd9, 4'd3, type_bike,  4'd2,  6'b000000, dec_admit,   3'd5, 18'o011112},
        '{4'd1, 4'd2,  4'd3, 4'd0, type_bike,  4'd3,  6'b000000, dec_admit,   3'd6, 18'o111112},
        '{4'd7, 4'd3,  4'd8, 4'd5, type_truck, 4'd4,  6'b000000, dec_decline, 3'd0, 18'o111112},
        '{4'd9, 4'd9,  4'd9, 4'd3, type_car,   4'd3,  6'b000000, dec_decline, 3'd0, 18'o111112},
        '{4'd1, 4'd2,  4'd3, 4'd0, type_bike,  4'd1,  6'b000000, dec_decline, 3'd0, 18'o111112},
        '{4'd1, 4'd2,  4'd3, 4'd4, type_truck, 4'd0,  6'b000011, dec_cash,    3'd0, 18'o111101},
        '{4'd1, 4'd2,  4'd3, 4'd4, type_truck, 4'd0,  6'b111110, dec_cash,    3'd0, 18'o000001},
        '{4'd1, 4'd2,  4'd3, 4'd0, type_truck, 4'd15, 6'b000010, dec_admit,   3'd2, 18'o000001},
        '{4'd7, 4'd3,  4'd8, 4'd5, type_truck, 4'd15, 6'b000001, dec_admit,   3'd2, 18'o000010},
        '{4'd1, 4'd2,  4'd3, 4'd0, type_truck, 4'd15, 6'b000000, dec_admit,   3'd1, 18'o000011}
    };

    logic                 clk;
    logic                 reset;
    logic                 vehicle_valid;
    logic [digit_w-1:0]   tag_a;
    logic [digit_w-1:0]   tag_b;
    logic [digit_w-1:0]   tag_c;
    logic [digit_w-1:0]   tag_d;
    vehicle_type_e        vehicle_type;
    logic [balance_w-1:0] balance;
    logic [lane_num-1:0]  lane_leave;
    logic                 decision_valid;
    decision_e            decision;
    logic [lane_w-1:0]    lane;
    lane_counts_t         lane_counts;
    logic [15:0]          lfsr_state;
    int                   model_counts [lane_num];

    toll_plaza dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic int take_bits(input int width);
        int value;
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Luhn weighted sum with digits 0 and 2 doubled
    function automatic int luhn_sum(input int a, input int b, input int c, input int d);
        int da;
        int dc;
        da = (2 * a > 9) ? 2 * a - 9 : 2 * a;
        dc = (2 * c > 9) ? 2 * c - 9 : 2 * c;
        return da + b + dc + d;
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Reference model fills in the expected results and advances the model queues
    task automatic model_fill(inout stim_row_t row);
        int toll;
        int first;
        int pick;
        int next_count;
        toll  = (row.vtype == type_truck) ? 5 : (row.vtype == type_car) ? 4 : 2;
        first = (row.vtype == type_truck) ? 1 : (row.vtype == type_car) ? 3 : 5;
        pick  = (model_counts[first] < model_counts[first - 1]) ? first + 1 : first;
        if (row.a > 4'd9 || row.b > 4'd9 || row.c > 4'd9 || row.d > 4'd9 ||
                luhn_sum(int'(row.a), int'(row.b), int'(row.c), int'(row.d)) % 10 != 0) begin
            row.dec = dec_cash;
        end else if (int'(row.bal) >= toll) begin
            row.dec = dec_admit;
        end else begin
            row.dec = dec_decline;
        end
        row.lane = (row.dec == dec_admit) ? lane_w'(pick) : lane_none;
        for (int i = 0; i < lane_num; i++) begin
            next_count = model_counts[i] - int'(row.leave[i]);
            if (row.dec == dec_admit && pick == i + 1) begin
                next_count++;
            end
            model_counts[i] = (next_count > 7) ? 7 : (next_count < 0) ? 0 : next_count;
            row.counts[i] = count_w'(model_counts[i]);
        end
    endtask

    task automatic run_vehicle(input stim_row_t row);
        int   latency;
        logic seen;
        @(posedge clk);
        vehicle_valid <= 1'b1;
        tag_a         <= row.a;
        tag_b         <= row.b;
        tag_c         <= row.c;
        tag_d         <= row.d;
        vehicle_type  <= row.vtype;
        balance       <= row.bal;
        latency = 0;
        seen    = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (decision_valid) begin
                seen = 1'b1;
            end else if (latency == wait_limit) begin
                $display("Timeout: no decision_valid within %0d cycles of a vehicle", wait_limit);
                $display("Some tests failed");
                $fatal(1);
            end else begin
                latency++;
                @(posedge clk);
                vehicle_valid <= 1'b0;
                // Sampled on the same edge as the decision
                lane_leave <= (latency == 1) ? row.leave : '0;
            end
        end
        check_value(latency, 2, "decision latency");
        check_value(int'(decision), int'(row.dec), "decision");
        check_value(int'(lane), int'(row.lane), "lane");
        check_value(int'(lane_counts), int'(row.counts), "lane_counts");
    endtask

    initial begin
        stim_row_t  row;
        logic [1:0] type_code;
        reset         <= 1'b1;
        vehicle_valid <= 1'b0;
        tag_a         <= '0;
        tag_b         <= '0;
        tag_c         <= '0;
        tag_d         <= '0;
        vehicle_type  <= type_truck;
        balance       <= '0;
        lane_leave    <= '0;
        lfsr_state = 16'd95;
        for (int i = 0; i < lane_num; i++) begin
            model_counts[i] = 0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Empty plaza and nothing decided yet
        repeat (4) begin
            @(negedge clk);
            check_value(int'(decision_valid), 0, "decision_valid before any vehicle");
            check_value(int'(lane_counts), 0, "lane_counts after reset");
        end
        check_value(int'(lane), int'(lane_none), "lane after reset");
        check_value(int'(decision), int'(dec_cash), "decision after reset");
        for (int i = 0; i < table_size; i++) begin
            row = rows[i];
            model_fill(row);
            run_vehicle(rows[i]);
        end
        // Bikes fill lanes 5 and 6, the last two land on a full lane 5
        for (int i = 0; i < 16; i++) begin
            row = '{4'd9, 4'd9, 4'd9, 4'd3, type_bike, 4'd15, 6'd0, dec_cash, lane_none, '0};
            model_fill(row);
            run_vehicle(row);
        end
        check_value(int'(lane_counts[4]), 7, "lane 5 count after saturation");
        for (int i = 0; i < random_count; i++) begin
            row.a = digit_w'(take_bits(4));
            row.b = digit_w'(take_bits(4));
            row.c = digit_w'(take_bits(4));
            row.d = digit_w'(take_bits(4));
            // About half the tags get a correct check digit
            if (take_bits(1) == 1) begin
                row.a = row.a % 4'd10;
                row.b = row.b % 4'd10;
                row.c = row.c % 4'd10;
                row.d = digit_w'((10 - luhn_sum(int'(row.a), int'(row.b), int'(row.c), 0) % 10) % 10);
            end
            type_code = 2'(take_bits(2));
            row.vtype = (type_code == 2'd3) ? type_bike : vehicle_type_e'(type_code);
            row.bal   = balance_w'(take_bits(4));
            row.leave = lane_num'(take_bits(6) & take_bits(6));
            model_fill(row);
            run_vehicle(row);
        end
        $display("All tests passed");
        $finish;
    end

endmodule
